//--- Bender.yml
package:
  name: mul_ctl

sources:
  - src/mul_arith_pkg.sv
  - src/mul_op_pkg.sv
  - src/mul_decode.sv
  - src/clmul_unit.sv
  - src/crc_unit.sv
  - src/bitmanip_unit.sv
  - src/mul_x_stage.sv
  - src/mul_ctl_top.sv
  - target: test
    files:
      - verif/tb_mul_ctl.sv

//--- project.f
src/mul_arith_pkg.sv
src/mul_op_pkg.sv
src/mul_decode.sv
src/clmul_unit.sv
src/crc_unit.sv
src/bitmanip_unit.sv
src/mul_x_stage.sv
src/mul_ctl_top.sv
verif/tb_mul_ctl.sv

//--- src/bitmanip_unit.sv
`timescale 1ns/1ps

module bitmanip_unit
   import mul_arith_pkg::*;
   import mul_op_pkg::*;
(
   input  mul_ctl_t ctl_i,
   input  word_t    rs1_i,
   input  word_t    rs2_i,
   output logic     bit_sel_o,
   output word_t    bit_result_o
);

   word_t clmul_result;
   word_t crc_result;

   // carry-less multiply of the raw operands
   clmul_unit u_clmul_unit (
      .rs1_i    (rs1_i),
      .rs2_i    (rs2_i),
      .sel_i    (ctl_i.clmul_sel),
      .result_o (clmul_result)
   );

   // crc step over the low bits of rs1
   crc_unit u_crc_unit (
      .data_i       (rs1_i),
      .en_i         (ctl_i.crc_sel.crc_en),
      .castagnoli_i (ctl_i.crc_sel.castagnoli),
      .size_i       (ctl_i.crc_sel.crc_size),
      .crc_o        (crc_result)
   );

   // both results are zero when not selected
   // so a plain or merges them
   assign bit_result_o = clmul_result | crc_result;

   // any bitmanip op overrides the product in the x stage
   assign bit_sel_o = ctl_i.bit_sel;

endmodule

//--- src/clmul_unit.sv
`timescale 1ns/1ps

module clmul_unit
   import mul_arith_pkg::*;
   import mul_op_pkg::*;
(
   input  word_t      rs1_i,
   input  word_t      rs2_i,
   input  clmul_sel_t sel_i,
   output word_t      result_o
);

   clmul_raw_t clmul_raw;

   // xor of rs1 shifted by every set bit position of rs2
   always_comb
   begin
      clmul_raw = '0;
      for (int i = 0; i < XLEN; i++)
      begin
         if (rs2_i[i])
         begin
            clmul_raw = clmul_raw ^ (clmul_raw_t'(rs1_i) << i);
         end
      end
   end

   // word select, a zero select gives zero
   // clmul   : product bits 31..0
   // clmulh  : product bits 62..32, top bit zero
   // clmulr  : product bits 62..31
   always_comb
   begin
      result_o = '0;
      if (sel_i[CLMUL_SEL_LO])
      begin
         result_o = result_o | clmul_raw[XLEN-1:0];
      end
      if (sel_i[CLMUL_SEL_HI])
      begin
         result_o = result_o | {1'b0, clmul_raw[2*XLEN-2:XLEN]};
      end
      if (sel_i[CLMUL_SEL_REV])
      begin
         result_o = result_o | clmul_raw[2*XLEN-2:XLEN-1];
      end
   end

endmodule

//--- src/crc_unit.sv
`timescale 1ns/1ps

module crc_unit
   import mul_arith_pkg::*;
   import mul_op_pkg::*;
(
   input  word_t     data_i,
   input  logic      en_i,
   input  logic      castagnoli_i,
   input  crc_size_e size_i,
   output word_t     crc_o
);

   word_t      poly;
   logic [5:0] n_steps;
   word_t      crc_val;

   assign poly = castagnoli_i ? CRC32C_POLY_REV : CRC32_POLY_REV;

   // bits of rs1 folded in by this step
   always_comb
   begin
      case (size_i)
         CRC_SZ_BYTE:
         begin
            n_steps = 6'd8;
         end
         CRC_SZ_HALF:
         begin
            n_steps = 6'd16;
         end
         default:
         begin
            n_steps = 6'd32;
         end
      endcase
   end

   // reflected crc, shift right and fold in the poly
   // whenever the bit leaving the register is set
   always_comb
   begin
      crc_val = data_i;
      for (int i = 0; i < XLEN; i++)
      begin
         if (i < n_steps)
         begin
            crc_val = (crc_val >> 1) ^ (poly & {XLEN{crc_val[0]}});
         end
      end
   end

   // quiet unless a crc op is selected
   assign crc_o = en_i ? crc_val : '0;

endmodule

//--- src/mul_arith_pkg.sv
package mul_arith_pkg;

   // data path width of the core
   localparam int unsigned XLEN = 32;

   // one architectural register value
   typedef logic [XLEN-1:0] word_t;

   // operand with one extra sign bit for the 33x33 multiplier
   typedef logic signed [XLEN:0] ext_word_t;

   // full signed product of two extended operands
   typedef logic signed [2*XLEN+1:0] prod_t;

   // carry-less product, top bit is always zero so it is left out
   typedef logic [2*XLEN-2:0] clmul_raw_t;

   // reflected CRC32 polynomial, normal form 0x04C11DB7
   localparam word_t CRC32_POLY_REV = 32'hEDB8_8320;

   // reflected CRC32C (castagnoli) polynomial, normal form 0x1EDC6F41
   localparam word_t CRC32C_POLY_REV = 32'h82F6_3B78;

endpackage

//--- src/mul_ctl_top.sv
`timescale 1ns/1ps

module mul_ctl_top
   import mul_arith_pkg::*;
   import mul_op_pkg::*;
#(
   parameter bit ENABLE_CLMUL = 1'b1,
   parameter bit ENABLE_CRC   = 1'b1
)
(
   input  logic    clk_i,
   input  logic    arst_n_i,
   input  logic    valid_i,
   input  mul_op_e op_i,
   input  word_t   rs1_i,
   input  word_t   rs2_i,
   output word_t   result_o
);

   // decoded packet, combinational from the inputs
   mul_ctl_t ctl;

   // bitmanip result ahead of the x stage register
   logic  bit_sel_d;
   word_t bit_result_d;

   mul_decode #(
      .ENABLE_CLMUL (ENABLE_CLMUL),
      .ENABLE_CRC   (ENABLE_CRC)
   ) u_mul_decode (
      .valid_i (valid_i),
      .op_i    (op_i),
      .rs1_i   (rs1_i),
      .rs2_i   (rs2_i),
      .ctl_o   (ctl)
   );

   bitmanip_unit u_bitmanip_unit (
      .ctl_i        (ctl),
      .rs1_i        (rs1_i),
      .rs2_i        (rs2_i),
      .bit_sel_o    (bit_sel_d),
      .bit_result_o (bit_result_d)
   );

   // one cycle of latency, result_o follows the register
   mul_x_stage u_mul_x_stage (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .ctl_i        (ctl),
      .bit_sel_i    (bit_sel_d),
      .bit_result_i (bit_result_d),
      .result_o     (result_o)
   );

endmodule

//--- src/mul_decode.sv
`timescale 1ns/1ps

module mul_decode
   import mul_arith_pkg::*;
   import mul_op_pkg::*;
#(
   parameter bit ENABLE_CLMUL = 1'b1,
   parameter bit ENABLE_CRC   = 1'b1
)
(
   input  logic     valid_i,
   input  mul_op_e  op_i,
   input  word_t    rs1_i,
   input  word_t    rs2_i,
   output mul_ctl_t ctl_o
);

   logic rs1_sign;
   logic rs2_sign;

   always_comb
   begin
      // everything starts out as MULHU
      rs1_sign    = 1'b0;
      rs2_sign    = 1'b0;
      ctl_o       = '0;
      ctl_o.valid = valid_i;

      case (op_i)
         MUL:
         begin
            // low word is the same for any operand sign
            ctl_o.low = 1'b1;
         end
         MULH:
         begin
            rs1_sign = 1'b1;
            rs2_sign = 1'b1;
         end
         MULHSU:
         begin
            rs1_sign = 1'b1;
         end
         CLMUL:
         begin
            ctl_o.clmul_sel[CLMUL_SEL_LO] = 1'b1;
         end
         CLMULH:
         begin
            ctl_o.clmul_sel[CLMUL_SEL_HI] = 1'b1;
         end
         CLMULR:
         begin
            ctl_o.clmul_sel[CLMUL_SEL_REV] = 1'b1;
         end
         CRC32_B, CRC32_H, CRC32_W, CRC32C_B, CRC32C_H, CRC32C_W:
         begin
            ctl_o.crc_sel.crc_en     = 1'b1;
            ctl_o.crc_sel.castagnoli = op_i inside {CRC32C_B, CRC32C_H, CRC32C_W};
            if (op_i inside {CRC32_B, CRC32C_B})
            begin
               ctl_o.crc_sel.crc_size = CRC_SZ_BYTE;
            end
            else if (op_i inside {CRC32_H, CRC32C_H})
            begin
               ctl_o.crc_sel.crc_size = CRC_SZ_HALF;
            end
            else
            begin
               ctl_o.crc_sel.crc_size = CRC_SZ_WORD;
            end
         end
         default:
         begin
            // MULHU and unused codes keep the defaults
            ctl_o.low = 1'b0;
         end
      endcase

      // a disabled extension falls back to MULHU
      if (!ENABLE_CLMUL)
      begin
         ctl_o.clmul_sel = '0;
      end
      if (!ENABLE_CRC)
      begin
         ctl_o.crc_sel = '0;
      end

      ctl_o.bit_sel = (|ctl_o.clmul_sel) | ctl_o.crc_sel.crc_en;

      // extra top bit carries the sign only for signed operands
      ctl_o.rs1_ext = {rs1_sign & rs1_i[XLEN-1], rs1_i};
      ctl_o.rs2_ext = {rs2_sign & rs2_i[XLEN-1], rs2_i};
   end

endmodule

//--- src/mul_op_pkg.sv
package mul_op_pkg;

   import mul_arith_pkg::*;

   // operation code seen by the execution unit
   typedef enum logic [3:0] {
      MUL      = 4'd0,
      MULH     = 4'd1,
      MULHSU   = 4'd2,
      MULHU    = 4'd3,
      CLMUL    = 4'd4,
      CLMULH   = 4'd5,
      CLMULR   = 4'd6,
      CRC32_B  = 4'd7,
      CRC32_H  = 4'd8,
      CRC32_W  = 4'd9,
      CRC32C_B = 4'd10,
      CRC32C_H = 4'd11,
      CRC32C_W = 4'd12
   } mul_op_e;

   // number of rs1 bits consumed by one CRC step
   typedef enum logic [1:0] {
      CRC_SZ_BYTE = 2'd0,
      CRC_SZ_HALF = 2'd1,
      CRC_SZ_WORD = 2'd2
   } crc_size_e;

   // bit positions inside the one-hot clmul select
   localparam int unsigned CLMUL_SEL_LO  = 0;
   localparam int unsigned CLMUL_SEL_HI  = 1;
   localparam int unsigned CLMUL_SEL_REV = 2;

   typedef logic [2:0] clmul_sel_t;

   typedef struct packed {
      logic      crc_en;
      logic      castagnoli;
      crc_size_e crc_size;
   } crc_sel_t;

   // decoded packet handed from decode to the bitmanip unit and x stage
   typedef struct packed {
      logic       valid;
      logic       low;
      ext_word_t  rs1_ext;
      ext_word_t  rs2_ext;
      logic       bit_sel;
      clmul_sel_t clmul_sel;
      crc_sel_t   crc_sel;
   } mul_ctl_t;

endpackage

//--- src/mul_x_stage.sv
`timescale 1ns/1ps

module mul_x_stage
   import mul_arith_pkg::*;
   import mul_op_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  mul_ctl_t ctl_i,
   input  logic     bit_sel_i,
   input  word_t    bit_result_i,
   output word_t    result_o
);

   logic      low_x;
   ext_word_t rs1_x;
   ext_word_t rs2_x;
   logic      bit_sel_x;
   word_t     bit_result_x;
   prod_t     prod_x;

   // x stage register, loads only on a valid op
   // so the result holds through idle cycles
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         low_x        <= 1'b0;
         rs1_x        <= '0;
         rs2_x        <= '0;
         bit_sel_x    <= 1'b0;
         bit_result_x <= '0;
      end
      else if (ctl_i.valid)
      begin
         low_x        <= ctl_i.low;
         rs1_x        <= ctl_i.rs1_ext;
         rs2_x        <= ctl_i.rs2_ext;
         bit_sel_x    <= bit_sel_i;
         bit_result_x <= bit_result_i;
      end
   end

   // 33x33 signed multiply covers all four mul variants
   assign prod_x = rs1_x * rs2_x;

   // bitmanip result wins, else low or high product word
   always_comb
   begin
      if (bit_sel_x)
      begin
         result_o = bit_result_x;
      end
      else if (low_x)
      begin
         result_o = prod_x[XLEN-1:0];
      end
      else
      begin
         result_o = prod_x[2*XLEN-1:XLEN];
      end
   end

endmodule

//--- verif/tb_mul_ctl.sv
`timescale 1ns/1ps

module tb_mul_ctl
   import mul_arith_pkg::*;
   import mul_op_pkg::*;
();

   // local copies of the DUT build options
   localparam bit ENABLE_CLMUL = 1'b1;
   localparam bit ENABLE_CRC   = 1'b1;

   localparam int CLK_PERIOD_NS = 40;
   localparam int RESET_CYCLES  = 16;
   localparam int N_RAND        = 16;
   localparam int N_SINGLE      = 8;
   localparam int N_STREAM      = 100;

   // steps per test, each test ends with one flush cycle
   localparam int TOTAL_STEPS = (4 + 1) + (36 + 4 * N_RAND + 1)
      + (3 * N_RAND + 3 * N_SINGLE + 1) + (2 + 6 * N_RAND + 1) + (N_STREAM + 10 + 1);
   localparam int TIMEOUT_NS = (TOTAL_STEPS + RESET_CYCLES + 100) * CLK_PERIOD_NS;

   // reflected polynomials, standard CRC32 and castagnoli
   localparam word_t POLY_CRC32  = 32'hEDB88320;
   localparam word_t POLY_CRC32C = 32'h82F63B78;

   logic    clk;
   logic    arst_n;
   logic    valid;
   mul_op_e op;
   word_t   rs1;
   word_t   rs2;
   word_t   result;

   // value result_o must show, and the op that set it
   word_t held;
   string held_tag;
   int    checks;
   int    fails;
   int    test_checks0;
   int    test_fails0;

   mul_ctl_top #(
      .ENABLE_CLMUL (ENABLE_CLMUL),
      .ENABLE_CRC   (ENABLE_CRC)
   ) u_mul_ctl_top (
      .clk_i    (clk),
      .arst_n_i (arst_n),
      .valid_i  (valid),
      .op_i     (op),
      .rs1_i    (rs1),
      .rs2_i    (rs2),
      .result_o (result)
   );

   always #(CLK_PERIOD_NS / 2) clk = ~clk;

   // reference model of one operation
   function automatic word_t compute_expected(input mul_op_e op_c, input word_t a,
                                              input word_t b);
      logic [63:0] uprod;
      longint      sprod;
      logic [63:0] cl;
      word_t       crc;
      word_t       poly;
      int          n;
      mul_op_e     eff;
      eff = op_c;
      // disabled extensions behave as MULHU
      if (!ENABLE_CLMUL && (op_c inside {CLMUL, CLMULH, CLMULR}))
      begin
         eff = MULHU;
      end
      if (!ENABLE_CRC && (op_c inside {CRC32_B, CRC32_H, CRC32_W, CRC32C_B, CRC32C_H, CRC32C_W}))
      begin
         eff = MULHU;
      end
      uprod = {32'b0, a} * {32'b0, b};
      case (eff)
         MUL:
         begin
            compute_expected = uprod[31:0];
         end
         MULH:
         begin
            sprod = longint'($signed(a)) * longint'($signed(b));
            compute_expected = sprod[63:32];
         end
         MULHSU:
         begin
            sprod = longint'($signed(a)) * longint'({32'b0, b});
            compute_expected = sprod[63:32];
         end
         MULHU:
         begin
            compute_expected = uprod[63:32];
         end
         CLMUL, CLMULH, CLMULR:
         begin
            cl = '0;
            for (int i = 0; i < 32; i++)
            begin
               if (b[i])
               begin
                  cl = cl ^ ({32'b0, a} << i);
               end
            end
            if (eff == CLMUL)
               compute_expected = cl[31:0];
            else if (eff == CLMULH)
               compute_expected = cl[63:32];
            else
               compute_expected = cl[62:31];
         end
         default:
         begin
            poly = (eff inside {CRC32C_B, CRC32C_H, CRC32C_W}) ? POLY_CRC32C : POLY_CRC32;
            if (eff inside {CRC32_B, CRC32C_B})
               n = 8;
            else if (eff inside {CRC32_H, CRC32C_H})
               n = 16;
            else
               n = 32;
            crc = a;
            // bit-serial reflected crc
            for (int i = 0; i < n; i++)
            begin
               crc = crc[0] ? ((crc >> 1) ^ poly) : (crc >> 1);
            end
            compute_expected = crc;
         end
      endcase
   endfunction

   task automatic check_result();
      checks++;
      assert (result === held)
      else
      begin
         $display("Mismatch result_o after %s: expected %08h got %08h", held_tag, held, result);
         fails++;
      end
   endtask

   // one cycle: check the last result, then drive the next inputs
   task automatic drive_op(input bit v, input mul_op_e o, input word_t a, input word_t b,
                           input word_t exp);
      @(posedge clk);
      #1;
      check_result();
      #1;
      valid = v;
      op    = o;
      rs1   = a;
      rs2   = b;
      if (v)
      begin
         held     = exp;
         held_tag = o.name();
      end
   endtask

   task automatic issue(input mul_op_e o, input word_t a, input word_t b);
      drive_op(1'b1, o, a, b, compute_expected(o, a, b));
   endtask

   // valid low with junk operands, result must hold
   task automatic idle_cycle();
      drive_op(1'b0, mul_op_e'($urandom_range(12, 0)), $urandom, $urandom, '0);
   endtask

   task automatic begin_test();
      test_checks0 = checks;
      test_fails0  = fails;
   endtask

   task automatic end_test(input string name);
      idle_cycle();
      $display("test %s done: %0d checks, %0d errors", name, checks - test_checks0,
               fails - test_fails0);
   endtask

   initial
   begin
      word_t corner[3];
      mul_op_e mul_ops[4];
      mul_op_e crc_ops[6];
      corner   = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000};
      mul_ops  = '{MUL, MULH, MULHSU, MULHU};
      crc_ops  = '{CRC32_B, CRC32_H, CRC32_W, CRC32C_B, CRC32C_H, CRC32C_W};
      void'($urandom(32'hdd041349));
      clk      = 1'b0;
      arst_n   = 1'b0;
      valid    = 1'b0;
      op       = MUL;
      rs1      = '0;
      rs2      = '0;
      held     = '0;
      held_tag = "reset";
      checks   = 0;
      fails    = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      arst_n = 1'b1;

      begin_test();
      repeat (4) idle_cycle();
      end_test("reset");

      begin_test();
      foreach (mul_ops[k])
      begin
         foreach (corner[i])
         begin
            foreach (corner[j])
            begin
               issue(mul_ops[k], corner[i], corner[j]);
            end
         end
         repeat (N_RAND) issue(mul_ops[k], $urandom, $urandom);
      end
      end_test("multiply");

      begin_test();
      for (int k = 0; k < 3; k++)
      begin
         repeat (N_RAND) issue(mul_op_e'(CLMUL + k), $urandom, $urandom);
         // single set bit of rs2 gives a shifted rs1
         repeat (N_SINGLE) issue(mul_op_e'(CLMUL + k), $urandom, 32'h1 << $urandom_range(31, 0));
      end
      end_test("clmul");

      begin_test();
      // known byte step vectors
      drive_op(1'b1, CRC32_B, 32'hFFFF_FF9E, $urandom, 32'h1748_41BC);
      drive_op(1'b1, CRC32C_B, 32'hFFFF_FF9E, $urandom, 32'h3E2F_BCCF);
      foreach (crc_ops[k])
      begin
         repeat (N_RAND) issue(crc_ops[k], $urandom, $urandom);
      end
      end_test("crc");

      begin_test();
      repeat (N_STREAM) issue(mul_op_e'($urandom_range(12, 0)), $urandom, $urandom);
      repeat (6) idle_cycle();
      issue(mul_op_e'($urandom_range(12, 0)), $urandom, $urandom);
      repeat (3) idle_cycle();
      end_test("stream_hold");

      $display("checks %0d, passed %0d, failed %0d", checks, checks - fails, fails);
      if (fails == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // ends a run that stopped making progress
   initial
   begin
      #(TIMEOUT_NS);
      $display("watchdog timeout, the tests did not finish in %0d ns", TIMEOUT_NS);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
